// File: rtl/isa_pkg.sv
// Instruction set package with word types, opcodes, ALU codes and field positions
`default_nettype none

package isa_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      shamt_t;

    typedef enum logic [4:0] {
        op_rtype = 5'b00000,
        op_j     = 5'b00001,
        op_bne   = 5'b00010,
        op_addi  = 5'b00101,
        op_blt   = 5'b00110,
        op_sw    = 5'b00111,
        op_lw    = 5'b01000
    } opcode_t;

    typedef enum logic [4:0] {
        alu_add = 5'b00000,
        alu_sub = 5'b00001,
        alu_and = 5'b00010,
        alu_or  = 5'b00011,
        alu_sll = 5'b00100,
        alu_sra = 5'b00101
    } alu_op_t;

    // Bit positions inside an instruction word
    localparam int op_hi    = 31;
    localparam int op_lo    = 27;
    localparam int rd_hi    = 26;
    localparam int rd_lo    = 22;
    localparam int rs_hi    = 21;
    localparam int rs_lo    = 17;
    localparam int rt_hi    = 16;
    localparam int rt_lo    = 12;
    localparam int shamt_hi = 11;
    localparam int shamt_lo = 7;
    localparam int aluop_hi = 6;
    localparam int aluop_lo = 2;
    localparam int imm_hi   = 16;
    localparam int imm_lo   = 0;
    localparam int imm_w    = 17;
    localparam int jt_w     = 27;   // Jump target sits in the low bits

endpackage

`default_nettype wire

// File: rtl/pipe_pkg.sv
// Pipeline package with control word, stage payloads and forwarding select
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    use_imm;       // Immediate replaces operand B
        logic    is_branch_ne;
        logic    is_branch_lt;
        logic    is_jump;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t insn;
        word_t pc_plus1;
    } fd_t;

    typedef struct packed {
        ctrl_t            ctrl;
        reg_idx_t         rd;
        reg_idx_t         rs;
        reg_idx_t         rt;           // Port B address holds rd for stores and branches
        shamt_t           shamt;
        word_t            imm;
        logic [jt_w-1:0]  jump_target;
        word_t            pc_plus1;
        word_t            op_a;
        word_t            op_b;
    } dx_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    store_data;
    } xm_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_read;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    load_data;
    } mw_t;

    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_xm   = 2'b01,
        fwd_mw   = 2'b10
    } fwd_sel_t;

endpackage

`default_nettype wire

// File: rtl/pc_counter.sv
// Program counter with sequential increment, stall hold and redirect load
`timescale 1ns/1ps
`default_nettype none

module pc_counter import isa_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  wire   clock,
    input  wire   rst,
    input  wire   stall,
    input  wire   redirect,
    input  word_t redirect_pc,
    output word_t pc,
    output word_t pc_next_seq
);

    assign pc_next_seq = pc + word_t'(1);   // Word addressed, so one per instruction

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;      // Taken branch or jump wins over a stall
        end else if (!stall) begin
            pc <= pc_next_seq;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pipe_reg.sv
// Generic pipeline stage register with hold and bubble insertion
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire      clock,
    input  wire      rst,
    input  wire      hold,
    input  wire      bubble,
    input  payload_t d,
    output payload_t q
);

    // An all-zero payload carries no control effect
    always_ff @(posedge clock) begin
        if (rst || bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
// Decode stage building control and operands from the fetched instruction
`timescale 1ns/1ps
`default_nettype none

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  fd_t      fd,
    output reg_idx_t ctrl_read_reg_a,
    output reg_idx_t ctrl_read_reg_b,
    input  word_t    data_read_reg_a,
    input  word_t    data_read_reg_b,
    output dx_t      dx
);

    opcode_t opcode;
    ctrl_t   ctrl;
    logic    reads_rd;

    assign opcode   = opcode_t'(fd.insn[op_hi:op_lo]);
    assign reads_rd = (opcode == op_sw) || (opcode == op_bne) || (opcode == op_blt);

    assign ctrl_read_reg_a = fd.insn[rs_hi:rs_lo];
    assign ctrl_read_reg_b = reads_rd ? fd.insn[rd_hi:rd_lo] : fd.insn[rt_hi:rt_lo];

    always_comb begin
        ctrl = '0;
        case (opcode)
            op_rtype: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_op_t'(fd.insn[aluop_hi:aluop_lo]);
            end
            op_addi: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            op_lw: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            op_sw: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;  // Address is rs plus offset
            end
            op_bne:  ctrl.is_branch_ne = 1'b1;
            op_blt:  ctrl.is_branch_lt = 1'b1;
            op_j:    ctrl.is_jump      = 1'b1;
            default: ctrl = '0;         // Unknown opcode acts as a no-op
        endcase
    end

    always_comb begin
        dx             = '0;
        dx.ctrl        = ctrl;
        dx.rd          = fd.insn[rd_hi:rd_lo];
        dx.rs          = ctrl_read_reg_a;
        dx.rt          = ctrl_read_reg_b;
        dx.shamt       = fd.insn[shamt_hi:shamt_lo];
        dx.imm         = {{(xlen-imm_w){fd.insn[imm_hi]}}, fd.insn[imm_hi:imm_lo]};
        dx.jump_target = fd.insn[jt_w-1:0];
        dx.pc_plus1    = fd.pc_plus1;
        dx.op_a        = data_read_reg_a;
        dx.op_b        = data_read_reg_b;
    end

endmodule

`default_nettype wire

// File: rtl/alu.sv
// Integer ALU for add, sub, logic and shifts, with compare flags
`timescale 1ns/1ps
`default_nettype none

module alu import isa_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    input  shamt_t  shamt,
    output word_t   result,
    output logic    not_equal,
    output logic    less_than
);

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_sll: result = a << shamt;
            alu_sra: result = word_t'($signed(a) >>> shamt);
            default: result = '0;
        endcase
    end

    // Flags feed branch resolution only
    assign not_equal = (a != b);
    assign less_than = ($signed(a) < $signed(b));

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
// Execute stage with operand forwarding, ALU and branch and jump resolution
`timescale 1ns/1ps
`default_nettype none

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  dx_t      dx,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  word_t    xm_result,
    input  word_t    mw_result,
    output xm_t      xm,
    output logic     redirect,
    output word_t    redirect_pc
);

    word_t src_a;
    word_t src_b;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    logic  is_branch;
    logic  not_equal;
    logic  less_than;
    logic  branch_taken;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t xm_val, input word_t mw_val);
        case (sel)
            fwd_xm:  return xm_val;
            fwd_mw:  return mw_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a = fwd_mux(fwd_a, dx.op_a, xm_result, mw_result);   // rs value
    assign src_b = fwd_mux(fwd_b, dx.op_b, xm_result, mw_result);   // rt, or rd on sw and branches

    assign is_branch = dx.ctrl.is_branch_ne || dx.ctrl.is_branch_lt;

    // Branches compare rd against rs
    always_comb begin
        if (is_branch) begin
            alu_a = src_b;
            alu_b = src_a;
        end else begin
            alu_a = src_a;
            alu_b = dx.ctrl.use_imm ? dx.imm : src_b;
        end
    end

    alu u_alu (
        .op        (dx.ctrl.alu_op),
        .a         (alu_a),
        .b         (alu_b),
        .shamt     (dx.shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    assign branch_taken = (dx.ctrl.is_branch_ne && not_equal) ||
                          (dx.ctrl.is_branch_lt && less_than);
    assign redirect     = branch_taken || dx.ctrl.is_jump;

    always_comb begin
        if (dx.ctrl.is_jump) begin
            redirect_pc = {{(xlen-jt_w){1'b0}}, dx.jump_target};
        end else begin
            redirect_pc = dx.pc_plus1 + dx.imm;     // Relative to the next instruction
        end
    end

    always_comb begin
        xm            = '0;
        xm.ctrl       = dx.ctrl;
        xm.rd         = dx.rd;
        xm.alu_result = alu_result;
        xm.store_data = src_b;      // Forwarded rd value for stores
    end

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
// Hazard unit for forwarding selects, load-use stall and redirect flush
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import isa_pkg::*, pipe_pkg::*; (
    input  word_t    fd_insn,
    input  dx_t      dx,
    input  xm_t      xm,
    input  mw_t      mw,
    input  wire      redirect,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b,
    output logic     stall,
    output logic     flush
);

    opcode_t  fd_op;
    reg_idx_t fd_rs;
    reg_idx_t fd_src_b;
    logic     fd_uses_rs;
    logic     fd_uses_b;
    logic     fd_reads_rd;
    logic     xm_writes;
    logic     mw_writes;

    // Loads never forward from XM and r0 never forwards
    assign xm_writes = xm.ctrl.reg_write && !xm.ctrl.mem_read && (xm.rd != '0);
    assign mw_writes = mw.reg_write && (mw.rd != '0);

    always_comb begin
        if (xm_writes && (xm.rd == dx.rs)) begin
            fwd_a = fwd_xm;
        end else if (mw_writes && (mw.rd == dx.rs)) begin
            fwd_a = fwd_mw;
        end else begin
            fwd_a = fwd_none;
        end
    end

    // dx.rt already holds rd for stores and branches
    always_comb begin
        if (xm_writes && (xm.rd == dx.rt)) begin
            fwd_b = fwd_xm;
        end else if (mw_writes && (mw.rd == dx.rt)) begin
            fwd_b = fwd_mw;
        end else begin
            fwd_b = fwd_none;
        end
    end

    // Sources of the instruction still in decode
    assign fd_op       = opcode_t'(fd_insn[op_hi:op_lo]);
    assign fd_rs       = fd_insn[rs_hi:rs_lo];
    assign fd_reads_rd = (fd_op == op_sw) || (fd_op == op_bne) || (fd_op == op_blt);
    assign fd_src_b    = fd_reads_rd ? fd_insn[rd_hi:rd_lo] : fd_insn[rt_hi:rt_lo];
    assign fd_uses_rs  = (fd_op != op_j);
    assign fd_uses_b   = fd_reads_rd || (fd_op == op_rtype);

    assign stall = dx.ctrl.mem_read && (dx.rd != '0) &&
                   ((fd_uses_rs && (fd_rs == dx.rd)) ||
                    (fd_uses_b && (fd_src_b == dx.rd)));

    assign flush = redirect;

endmodule

`default_nettype wire

// File: rtl/processor.sv
// Five-stage pipelined processor core with external memory and register file ports
`timescale 1ns/1ps
`default_nettype none

module processor import isa_pkg::*, pipe_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  wire      clock,
    input  wire      rst,
    // Instruction memory
    output word_t    address_imem,
    input  word_t    q_imem,
    // Data memory
    output word_t    address_dmem,
    output word_t    data,
    output logic     wren,
    input  word_t    q_dmem,
    // Register file
    output logic     ctrl_write_enable,
    output reg_idx_t ctrl_write_reg,
    output reg_idx_t ctrl_read_reg_a,
    output reg_idx_t ctrl_read_reg_b,
    output word_t    data_write_reg,
    input  word_t    data_read_reg_a,
    input  word_t    data_read_reg_b
);

    word_t    pc_next_seq;
    word_t    redirect_pc;
    word_t    mw_result;
    logic     redirect;
    logic     stall;
    logic     flush;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    fd_t      fd_d;
    fd_t      fd_q;
    dx_t      dx_d;
    dx_t      dx_q;
    xm_t      xm_d;
    xm_t      xm_q;
    mw_t      mw_d;
    mw_t      mw_q;

    pc_counter #(.reset_pc(reset_pc)) u_pc (
        .clock       (clock),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (address_imem),
        .pc_next_seq (pc_next_seq)
    );

    assign fd_d.insn     = q_imem;
    assign fd_d.pc_plus1 = pc_next_seq;

    pipe_reg #(.payload_t(fd_t)) u_fd (
        .clock (clock), .rst (rst), .hold (stall), .bubble (flush), .d (fd_d), .q (fd_q)
    );

    decode_stage u_decode (
        .fd              (fd_q),
        .ctrl_read_reg_a (ctrl_read_reg_a),
        .ctrl_read_reg_b (ctrl_read_reg_b),
        .data_read_reg_a (data_read_reg_a),
        .data_read_reg_b (data_read_reg_b),
        .dx              (dx_d)
    );

    pipe_reg #(.payload_t(dx_t)) u_dx (
        .clock (clock), .rst (rst), .hold (1'b0), .bubble (stall || flush), .d (dx_d), .q (dx_q)
    );

    execute_stage u_execute (
        .dx          (dx_q),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .xm_result   (xm_q.alu_result),
        .mw_result   (mw_result),
        .xm          (xm_d),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    pipe_reg #(.payload_t(xm_t)) u_xm (
        .clock (clock), .rst (rst), .hold (1'b0), .bubble (1'b0), .d (xm_d), .q (xm_q)
    );

    // Memory stage
    assign address_dmem = xm_q.alu_result;
    assign data         = xm_q.store_data;
    assign wren         = xm_q.ctrl.mem_write;

    assign mw_d.reg_write  = xm_q.ctrl.reg_write;
    assign mw_d.mem_read   = xm_q.ctrl.mem_read;
    assign mw_d.rd         = xm_q.rd;
    assign mw_d.alu_result = xm_q.alu_result;
    assign mw_d.load_data  = q_dmem;

    pipe_reg #(.payload_t(mw_t)) u_mw (
        .clock (clock), .rst (rst), .hold (1'b0), .bubble (1'b0), .d (mw_d), .q (mw_q)
    );

    // Writeback masks any write to r0
    assign mw_result         = mw_q.mem_read ? mw_q.load_data : mw_q.alu_result;
    assign data_write_reg    = mw_result;
    assign ctrl_write_reg    = mw_q.rd;
    assign ctrl_write_enable = mw_q.reg_write && (mw_q.rd != '0);

    hazard_unit u_hazard (
        .fd_insn  (fd_q.insn),
        .dx       (dx_q),
        .xm       (xm_q),
        .mw       (mw_q),
        .redirect (redirect),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .stall    (stall),
        .flush    (flush)
    );

endmodule

`default_nettype wire

// File: sim/tb_processor.sv
// Testbench running random programs on the core against an instruction-set model
`timescale 1ns/1ps
`default_nettype none

module tb_processor import isa_pkg::*; ();

    localparam word_t reset_pc    = 32'h40;
    localparam int    clk_period  = 8;
    localparam int    num_tests   = 12;
    localparam int    prog_len    = 40;
    localparam int    run_cycles  = 120;
    localparam int    test_cycles = 136;
    localparam int    margin_ns   = 2000;

    typedef struct packed {
        reg_idx_t rd;
        word_t    value;
    } reg_write_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic     clock;
    logic     rst;
    word_t    address_imem;
    word_t    q_imem;
    word_t    address_dmem;
    word_t    data;
    logic     wren;
    word_t    q_dmem;
    logic     ctrl_write_enable;
    reg_idx_t ctrl_write_reg;
    reg_idx_t ctrl_read_reg_a;
    reg_idx_t ctrl_read_reg_b;
    word_t    data_write_reg;
    word_t    data_read_reg_a;
    word_t    data_read_reg_b;

    word_t imem [0:255];
    word_t dmem [0:255];
    word_t regs [0:31];
    word_t prog [0:prog_len-1];
    word_t init_regs [0:7];

    reg_write_t exp_writes[$];
    reg_write_t got_writes[$];
    store_t     exp_stores[$];
    store_t     got_stores[$];

    integer seed = 69;
    int     errors;
    int     failed_tests;
    int     total_exp_writes;
    int     total_got_writes;
    logic   collecting;

    processor #(.reset_pc(reset_pc)) DUT (
        .clock             (clock),
        .rst               (rst),
        .address_imem      (address_imem),
        .q_imem            (q_imem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .ctrl_read_reg_a   (ctrl_read_reg_a),
        .ctrl_read_reg_b   (ctrl_read_reg_b),
        .data_write_reg    (data_write_reg),
        .data_read_reg_a   (data_read_reg_a),
        .data_read_reg_b   (data_read_reg_b)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    // Memories and register file answer in the same cycle
    assign q_imem = imem[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[7:0]];

    // Write-through register file returns the value being written
    assign data_read_reg_a = (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_a &&
                              ctrl_read_reg_a != '0) ? data_write_reg : regs[ctrl_read_reg_a];
    assign data_read_reg_b = (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_b &&
                              ctrl_read_reg_b != '0) ? data_write_reg : regs[ctrl_read_reg_b];

    always @(posedge clock) begin
        if (ctrl_write_enable && ctrl_write_reg != '0) begin
            regs[ctrl_write_reg] <= data_write_reg;
        end
        if (wren) begin
            dmem[address_dmem[7:0]] <= data;
        end
        if (collecting) begin
            assert (!(ctrl_write_enable && ctrl_write_reg == '0)) else begin
                $display("Register write enabled for r0 at %0t ns", $time);
                errors++;
            end
            if (ctrl_write_enable) begin
                got_writes.push_back(reg_write_t'{ctrl_write_reg, data_write_reg});
            end
            if (wren) begin
                got_stores.push_back(store_t'{address_dmem, data});
            end
        end
    end

    function automatic word_t fill_word(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {a, ~a, a ^ 8'h5a, a + 8'h3c};
    endfunction

    function automatic word_t rtype_word(input reg_idx_t rd, input reg_idx_t rs,
                                         input reg_idx_t rt, input logic [4:0] sh,
                                         input logic [4:0] aop);
        return {op_rtype, rd, rs, rt, sh, aop, 2'b00};
    endfunction

    function automatic word_t itype_word(input opcode_t op, input reg_idx_t rd,
                                         input reg_idx_t rs, input logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic word_t jump_word(input logic [26:0] target);
        return {op_j, target};
    endfunction

    function automatic word_t alu_model(input logic [4:0] aop, input word_t a, input word_t b,
                                        input logic [4:0] sh);
        case (aop)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_sll: return a << sh;
            alu_sra: return $signed(a) >>> sh;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // Kind 0 is ALU only, kind 1 is memory heavy, kind 2 is control flow
    task automatic build_program(input int kind);
        int          i;
        int          pick;
        int          off;
        int          aop_sel;
        logic [16:0] imm;
        reg_idx_t    rd;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    prev_rd;
        opcode_t     op;
        prev_rd = '0;
        for (i = 0; i < prog_len - 1; i++) begin
            pick    = $random(seed) & 7;
            rd      = $random(seed) & 7;
            rs      = $random(seed) & 7;
            rt      = $random(seed) & 7;
            aop_sel = ($random(seed) & 32'h7fffffff) % 6;
            imm     = $random(seed);
            off     = $random(seed) & 7;
            if (off > prog_len - 2 - i) begin
                off = prog_len - 2 - i;     // Targets stay inside the program
            end
            if ($random(seed) & 1) begin
                rs = prev_rd;
            end
            case (kind)
                0: op = (pick < 4) ? op_rtype : op_addi;
                1: op = (pick < 3) ? op_lw : (pick < 6) ? op_sw :
                        (pick == 6) ? op_rtype : op_addi;
                default: op = (pick < 2) ? op_bne : (pick < 4) ? op_blt : (pick == 4) ? op_j :
                              (pick < 7) ? op_rtype : op_addi;
            endcase
            if (op == op_sw && ($random(seed) & 1)) begin
                rd = prev_rd;   // Store of a value just computed
            end
            case (op)
                op_rtype:     prog[i] = rtype_word(rd, rs, rt, imm[11:7], aop_sel);
                op_addi:      prog[i] = itype_word(op, rd, rs, imm);
                op_lw, op_sw: prog[i] = itype_word(op, rd, rs, imm & 17'hf);
                op_j:         prog[i] = jump_word(reset_pc + i + 1 + off);
                default:      prog[i] = itype_word(op, rd, rs, off);
            endcase
            if (op == op_rtype || op == op_addi || op == op_lw) begin
                prev_rd = rd;
            end
        end
        prog[prog_len-1] = jump_word(reset_pc + prog_len - 1);     // Parks the core
        init_regs[0] = '0;
        for (i = 1; i < 8; i++) begin
            init_regs[i] = $random(seed) & 32'hff;
        end
    endtask

    task automatic run_model();
        word_t    m_regs [0:31];
        word_t    m_mem [0:255];
        word_t    pc;
        word_t    insn;
        word_t    imm;
        word_t    addr;
        word_t    a;
        word_t    b;
        word_t    d;
        word_t    result;
        logic     writes;
        reg_idx_t rd;
        int       i;
        int       steps;
        exp_writes.delete();
        exp_stores.delete();
        for (i = 0; i < 32; i++) begin
            m_regs[i] = (i < 8) ? init_regs[i] : '0;
        end
        for (i = 0; i < 256; i++) begin
            m_mem[i] = fill_word(i);
        end
        pc    = reset_pc;
        steps = 0;
        while (pc != reset_pc + prog_len - 1 && steps < 4 * prog_len) begin
            insn   = prog[pc - reset_pc];
            rd     = insn[26:22];
            a      = m_regs[insn[21:17]];
            b      = m_regs[insn[16:12]];
            d      = m_regs[rd];
            imm    = {{15{insn[16]}}, insn[16:0]};
            addr   = a + imm;
            writes = 1'b0;
            result = '0;
            pc     = pc + 1;
            case (insn[31:27])
                op_rtype: begin
                    writes = 1'b1;
                    result = alu_model(insn[6:2], a, b, insn[11:7]);
                end
                op_addi: begin
                    writes = 1'b1;
                    result = addr;
                end
                op_lw: begin
                    writes = 1'b1;
                    result = m_mem[addr[7:0]];
                end
                op_sw: begin
                    exp_stores.push_back(store_t'{addr, d});
                    m_mem[addr[7:0]] = d;
                end
                op_bne:  if (d != a) pc = pc + imm;
                op_blt:  if ($signed(d) < $signed(a)) pc = pc + imm;
                op_j:    pc = {5'b0, insn[26:0]};
                default: writes = 1'b0;
            endcase
            if (writes && rd != '0) begin
                m_regs[rd] = result;
                exp_writes.push_back(reg_write_t'{rd, result});
            end
            steps++;
        end
    endtask

    task automatic load_memories();
        int i;
        for (i = 0; i < 256; i++) begin
            if (i >= reset_pc && i < reset_pc + prog_len) begin
                imem[i] = prog[i - reset_pc];
            end else begin
                imem[i] = '0;
            end
            dmem[i] = fill_word(i);
        end
        for (i = 0; i < 32; i++) begin
            regs[i] = (i < 8) ? init_regs[i] : '0;
        end
    endtask

    task automatic check_reset_outputs();
        check_value("address_imem", reset_pc, address_imem);
        check_value("wren", '0, {31'b0, wren});
        check_value("ctrl_write_enable", '0, {31'b0, ctrl_write_enable});
    endtask

    task automatic compare_lists();
        int i;
        check_value("register write count", exp_writes.size(), got_writes.size());
        for (i = 0; i < exp_writes.size() && i < got_writes.size(); i++) begin
            check_value("ctrl_write_reg", exp_writes[i].rd, got_writes[i].rd);
            check_value("data_write_reg", exp_writes[i].value, got_writes[i].value);
        end
        check_value("store count", exp_stores.size(), got_stores.size());
        for (i = 0; i < exp_stores.size() && i < got_stores.size(); i++) begin
            check_value("address_dmem", exp_stores[i].addr, got_stores[i].addr);
            check_value("data", exp_stores[i].data, got_stores[i].data);
        end
    endtask

    task automatic run_test(input int num, input int kind);
        int cyc;
        int errors_before;
        errors_before = errors;
        build_program(kind);
        run_model();
        got_writes.delete();
        got_stores.delete();
        @(posedge clock);
        rst <= 1'b1;
        for (cyc = 0; cyc < 16; cyc++) begin
            @(posedge clock);
            if (cyc == 15) begin
                rst <= 1'b0;
            end
            @(negedge clock);
            if (cyc == 0) begin
                load_memories();    // Core already holds bubbles here
            end
            check_reset_outputs();  // Last pass is the first cycle out of reset
        end
        collecting = 1'b1;
        repeat (run_cycles) @(posedge clock);
        @(negedge clock);
        collecting = 1'b0;
        compare_lists();
        total_exp_writes += exp_writes.size();
        total_got_writes += got_writes.size();
        if (errors != errors_before) begin
            failed_tests++;
        end
        $display("test %0d kind %0d: %0d register writes, %0d stores, %s", num, kind,
                 got_writes.size(), got_stores.size(),
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int i;
        rst              = 1'b1;
        collecting       = 1'b0;
        errors           = 0;
        failed_tests     = 0;
        total_exp_writes = 0;
        total_got_writes = 0;
        for (i = 0; i < prog_len; i++) begin
            prog[i] = '0;
        end
        for (i = 0; i < 8; i++) begin
            init_regs[i] = '0;
        end
        load_memories();
        for (i = 0; i < num_tests; i++) begin
            run_test(i, i % 3);
        end
        check_value("total register writes", total_exp_writes, total_got_writes);
        $display("tests %0d, failed %0d, register writes %0d, errors %0d",
                 num_tests, failed_tests, total_got_writes, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog sized from the test count and cycles per test
    initial begin
        #(num_tests * test_cycles * clk_period + margin_ns);
        $display("Timeout, the run did not finish within %0d ns",
                 num_tests * test_cycles * clk_period + margin_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: processor.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/pc_counter.sv
rtl/pipe_reg.sv
rtl/decode_stage.sv
rtl/alu.sv
rtl/execute_stage.sv
rtl/hazard_unit.sv
rtl/processor.sv
sim/tb_processor.sv

// File: Bender.yml
package:
  name: processor

sources:
  - rtl/isa_pkg.sv
  - rtl/pipe_pkg.sv
  - rtl/pc_counter.sv
  - rtl/pipe_reg.sv
  - rtl/decode_stage.sv
  - rtl/alu.sv
  - rtl/execute_stage.sv
  - rtl/hazard_unit.sv
  - rtl/processor.sv
  - target: simulation
    files:
      - sim/tb_processor.sv
